/* axi_lite_uart.sv */
`timescale 1ns/10ps
`include "uart_defines.svh"

module axi_lite_uart (
    input  logic                    aclk,
    input  logic                    aresetn,
    input  logic [`UART_ADDR_W-1:0] s_axi_awaddr,
    input  logic [2:0]              s_axi_awprot,
    input  logic                    s_axi_awvalid,
    output logic                    s_axi_awready,
    input  logic [31:0]             s_axi_wdata,
    input  logic [3:0]              s_axi_wstrb,
    input  logic                    s_axi_wvalid,
    output logic                    s_axi_wready,
    output logic [1:0]              s_axi_bresp,
    output logic                    s_axi_bvalid,
    input  logic                    s_axi_bready,
    input  logic [`UART_ADDR_W-1:0] s_axi_araddr,
    input  logic [2:0]              s_axi_arprot,
    input  logic                    s_axi_arvalid,
    output logic                    s_axi_arready,
    output logic [31:0]             s_axi_rdata,
    output logic [1:0]              s_axi_rresp,
    output logic                    s_axi_rvalid,
    input  logic                    s_axi_rready,
    output logic                    uart_txd,
    input  logic                    uart_rxd
);
    uart_pkg::uart_ctrl_t    ctrl;
    uart_pkg::rx_err_t       rx_err;
    logic [15:0]             baud_div;
    logic                    tick;
    logic                    tx_push;
    logic                    tx_pop;
    logic                    tx_empty;
    logic                    tx_full;
    logic [`UART_DATA_W-1:0] tx_wdata;
    logic [`UART_DATA_W-1:0] tx_rdata;
    logic                    rx_push;
    logic                    rx_pop;
    logic                    rx_empty;
    logic                    rx_full;
    logic [`UART_DATA_W-1:0] rx_wdata;
    logic [`UART_DATA_W-1:0] rx_rdata;

    // Protection bits have no meaning for this slave
    axil_uart_regs regs0 (
        .aclk, .aresetn,
        .s_axi_awaddr, .s_axi_awvalid, .s_axi_awready,
        .s_axi_wdata, .s_axi_wstrb, .s_axi_wvalid, .s_axi_wready,
        .s_axi_bresp, .s_axi_bvalid, .s_axi_bready,
        .s_axi_araddr, .s_axi_arvalid, .s_axi_arready,
        .s_axi_rdata, .s_axi_rresp, .s_axi_rvalid, .s_axi_rready,
        .ctrl, .baud_div,
        .tx_push, .tx_wdata, .tx_empty, .tx_full,
        .rx_pop, .rx_rdata, .rx_empty, .rx_full, .rx_err
    );

    baud_tick_gen tick0 (.aclk, .aresetn, .baud_div, .tick);

    byte_fifo tx_fifo (
        .aclk, .aresetn,
        .push(tx_push), .pop(tx_pop), .wr_data(tx_wdata), .rd_data(tx_rdata),
        .empty(tx_empty), .full(tx_full)
    );

    byte_fifo rx_fifo (
        .aclk, .aresetn,
        .push(rx_push), .pop(rx_pop), .wr_data(rx_wdata), .rd_data(rx_rdata),
        .empty(rx_empty), .full(rx_full)
    );

    uart_tx tx0 (
        .aclk, .aresetn, .ctrl, .tick,
        .fifo_empty(tx_empty), .fifo_data(tx_rdata), .fifo_pop(tx_pop), .txd(uart_txd)
    );

    uart_rx rx0 (
        .aclk, .aresetn, .ctrl, .tick, .rxd(uart_rxd),
        .fifo_full(rx_full), .fifo_push(rx_push), .fifo_data(rx_wdata), .err(rx_err)
    );

endmodule

/* axil_uart_regs.sv */
`timescale 1ns/10ps
`include "uart_defines.svh"

module axil_uart_regs (
    input  logic                    aclk,
    input  logic                    aresetn,
    input  logic [`UART_ADDR_W-1:0] s_axi_awaddr,
    input  logic                    s_axi_awvalid,
    output logic                    s_axi_awready,
    input  logic [31:0]             s_axi_wdata,
    input  logic [3:0]              s_axi_wstrb,
    input  logic                    s_axi_wvalid,
    output logic                    s_axi_wready,
    output logic [1:0]              s_axi_bresp,
    output logic                    s_axi_bvalid,
    input  logic                    s_axi_bready,
    input  logic [`UART_ADDR_W-1:0] s_axi_araddr,
    input  logic                    s_axi_arvalid,
    output logic                    s_axi_arready,
    output logic [31:0]             s_axi_rdata,
    output logic [1:0]              s_axi_rresp,
    output logic                    s_axi_rvalid,
    input  logic                    s_axi_rready,
    output uart_pkg::uart_ctrl_t    ctrl,
    output logic [15:0]             baud_div,
    output logic                    tx_push,
    output logic [`UART_DATA_W-1:0] tx_wdata,
    input  logic                    tx_empty,
    input  logic                    tx_full,
    output logic                    rx_pop,
    input  logic [`UART_DATA_W-1:0] rx_rdata,
    input  logic                    rx_empty,
    input  logic                    rx_full,
    input  uart_pkg::rx_err_t       rx_err
);
    uart_pkg::reg_addr_t    wr_addr;
    uart_pkg::reg_addr_t    rd_addr;
    logic [31:0]            wr_data;
    logic [3:0]             wr_strb;
    logic                   wr_pend;    // Write captured, applied next edge
    logic                   rd_pend;
    uart_pkg::uart_status_t status;

    assign s_axi_bresp = 2'b00;         // OKAY
    assign s_axi_rresp = 2'b00;

    assign tx_push  = wr_pend && (wr_addr == uart_pkg::REG_TX_DATA) && wr_strb[0]
                      && !tx_full && ctrl.enable && ctrl.tx_en;
    assign tx_wdata = wr_data[`UART_DATA_W-1:0];
    assign rx_pop   = rd_pend && (rd_addr == uart_pkg::REG_RX_DATA)
                      && !rx_empty && ctrl.enable && ctrl.rx_en;

    // Address and data are taken together, one write in flight
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            s_axi_awready <= 1'b0;
            s_axi_wready  <= 1'b0;
            wr_pend       <= 1'b0;
            s_axi_bvalid  <= 1'b0;
        end else begin
            s_axi_awready <= 1'b0;
            s_axi_wready  <= 1'b0;
            wr_pend       <= s_axi_awready;
            if (!s_axi_awready && !wr_pend && !s_axi_bvalid && s_axi_awvalid && s_axi_wvalid) begin
                s_axi_awready <= 1'b1;
                s_axi_wready  <= 1'b1;
            end
            if (wr_pend) begin
                s_axi_bvalid <= 1'b1;
            end else if (s_axi_bready) begin
                s_axi_bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            s_axi_arready <= 1'b0;
            rd_pend       <= 1'b0;
            s_axi_rvalid  <= 1'b0;
        end else begin
            s_axi_arready <= !s_axi_arready && !rd_pend && !s_axi_rvalid && s_axi_arvalid;
            rd_pend       <= s_axi_arready;
            if (rd_pend) begin
                s_axi_rvalid <= 1'b1;
            end else if (s_axi_rready) begin
                s_axi_rvalid <= 1'b0;
            end
        end
    end

    // Captured on the handshake edge
    always_ff @(posedge aclk) begin
        if (s_axi_awready) begin
            wr_addr <= uart_pkg::reg_addr_t'(s_axi_awaddr[4:2]);
            wr_data <= s_axi_wdata;
            wr_strb <= s_axi_wstrb;
        end
        if (s_axi_arready) begin
            rd_addr <= uart_pkg::reg_addr_t'(s_axi_araddr[4:2]);
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            ctrl     <= '0;
            baud_div <= 16'(`UART_DEFAULT_DIV);
        end else if (wr_pend) begin
            case (wr_addr)
                uart_pkg::REG_CTRL: begin
                    if (wr_strb[0]) begin
                        ctrl <= uart_pkg::uart_ctrl_t'(wr_data[2:0]);
                    end
                end
                uart_pkg::REG_BAUD: begin
                    if (wr_strb[0]) begin
                        baud_div[7:0] <= wr_data[7:0];
                    end
                    if (wr_strb[1]) begin
                        baud_div[15:8] <= wr_data[15:8];
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // Read data stays put while rvalid waits for rready
    always_ff @(posedge aclk) begin
        if (rd_pend) begin
            case (rd_addr)
                uart_pkg::REG_CTRL:    s_axi_rdata <= 32'(ctrl);
                uart_pkg::REG_STATUS:  s_axi_rdata <= 32'(status);
                uart_pkg::REG_BAUD:    s_axi_rdata <= 32'(baud_div);
                uart_pkg::REG_RX_DATA: s_axi_rdata <= rx_pop ? 32'(rx_rdata) : 32'd0;
                default:               s_axi_rdata <= 32'd0;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            status <= uart_pkg::uart_status_t'(6'h05);   // Both FIFOs empty
        end else begin
            status.tx_empty    <= tx_empty;
            status.tx_full     <= tx_full;
            status.rx_empty    <= rx_empty;
            status.rx_full     <= rx_full;
            status.frame_err   <= status.frame_err | rx_err.frame;
            status.overrun_err <= status.overrun_err | rx_err.overrun;
        end
    end

    a_bvalid_hold : assert property (@(posedge aclk) disable iff (!aresetn)
        s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid);

endmodule

/* baud_tick_gen.sv */
`timescale 1ns/10ps

module baud_tick_gen (
    input  logic        aclk,
    input  logic        aresetn,
    input  logic [15:0] baud_div,
    output logic        tick
);
    logic [15:0] cnt;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else if (cnt >= baud_div - 16'd1) begin   // Also catches a divisor lowered mid-count
            cnt  <= '0;
            tick <= 1'b1;
        end else begin
            cnt  <= cnt + 16'd1;
            tick <= 1'b0;
        end
    end

    // A zero divisor written over AXI would stall both serial engines
    a_div_nonzero : assert property (@(posedge aclk) disable iff (!aresetn) baud_div != 16'd0);

endmodule

/* byte_fifo.sv */
`timescale 1ns/10ps
`include "uart_defines.svh"

module byte_fifo #(
    parameter int DEPTH = `UART_FIFO_DEPTH
) (
    input  logic                    aclk,
    input  logic                    aresetn,
    input  logic                    push,
    input  logic                    pop,
    input  logic [`UART_DATA_W-1:0] wr_data,
    output logic [`UART_DATA_W-1:0] rd_data,
    output logic                    empty,
    output logic                    full
);
    localparam int AW = $clog2(DEPTH);

    logic [`UART_DATA_W-1:0] mem [DEPTH];
    logic [AW:0]             wr_ptr;   // Extra top bit tells full from empty
    logic [AW:0]             rd_ptr;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr[AW-1:0]] <= wr_data;
        end
    end

    assign rd_data = mem[rd_ptr[AW-1:0]];   // Head, valid while not empty
    assign empty   = (wr_ptr == rd_ptr);
    assign full    = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    // Callers gate their strobes on the levels driven here
    a_no_push_full : assert property (@(posedge aclk) disable iff (!aresetn) push |-> !full);
    a_no_pop_empty : assert property (@(posedge aclk) disable iff (!aresetn) pop |-> !empty);

endmodule

/* flist.f */
+incdir+.
uart_pkg.sv
byte_fifo.sv
baud_tick_gen.sv
uart_tx.sv
uart_rx.sv
axil_uart_regs.sv
axi_lite_uart.sv
tb_axi_lite_uart.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_axi_lite_uart -f flist.f -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "STATUS: PASS"; then
    exit 0
fi
exit 1

/* tb_axi_lite_uart.sv */
`timescale 1ns/10ps
`include "uart_defines.svh"

module tb_axi_lite_uart;
    localparam int WAIT_LIMIT = 3000;   // Cycles or polls per wait

    logic        aclk = 1'b0;
    logic        aresetn;
    logic [4:0]  s_axi_awaddr;
    logic [2:0]  s_axi_awprot;
    logic        s_axi_awvalid;
    logic        s_axi_awready;
    logic [31:0] s_axi_wdata;
    logic [3:0]  s_axi_wstrb;
    logic        s_axi_wvalid;
    logic        s_axi_wready;
    logic [1:0]  s_axi_bresp;
    logic        s_axi_bvalid;
    logic        s_axi_bready;
    logic [4:0]  s_axi_araddr;
    logic [2:0]  s_axi_arprot;
    logic        s_axi_arvalid;
    logic        s_axi_arready;
    logic [31:0] s_axi_rdata;
    logic [1:0]  s_axi_rresp;
    logic        s_axi_rvalid;
    logic        s_axi_rready;
    logic        uart_txd;
    logic        uart_rxd;
    logic        loopback;     // Serial line mux select
    logic        rxd_force;
    logic [3:0]  wstrb_sel;    // Strobe used by golden writes
    logic [15:0] div_model;
    logic [7:0]  rx_model [$]; // Bytes the RX FIFO should hold
    int          errors;
    int          timeouts;

    assign uart_rxd = loopback ? uart_txd : rxd_force;

    always #50 aclk = ~aclk;

    axi_lite_uart dut0 (.*);

    // All bus tasks start and end on a falling edge
    task automatic axi_write(input logic [4:0] addr, input logic [31:0] data);
        int n;
        s_axi_awaddr  = addr;
        s_axi_wdata   = data;
        s_axi_wstrb   = wstrb_sel;
        s_axi_awvalid = 1'b1;
        s_axi_wvalid  = 1'b1;
        n = 0;
        do begin
            @(negedge aclk);
            n++;
        end while (!s_axi_awready && n < WAIT_LIMIT);
        if (!s_axi_awready || !s_axi_wready) begin
            $display("Timeout at %0t waiting for the write address and data ready", $time);
            timeouts++;
        end else begin
            @(negedge aclk);   // Valid held over the handshake edge
        end
        s_axi_awvalid = 1'b0;
        s_axi_wvalid  = 1'b0;
        n = 0;
        while (!s_axi_bvalid && n < WAIT_LIMIT) begin
            @(negedge aclk);
            n++;
        end
        if (!s_axi_bvalid) begin
            $display("Timeout at %0t waiting for the write response", $time);
            timeouts++;
        end else begin
            if (s_axi_bresp != 2'b00) begin
                $display("Error: %0t s_axi_bresp expected %h actual %h", $time, 2'b00, s_axi_bresp);
                errors++;
            end
            s_axi_bready = 1'b1;
            @(negedge aclk);
            s_axi_bready = 1'b0;
        end
    endtask

    task automatic axi_read(input logic [4:0] addr, output logic [31:0] data);
        int n;
        data          = '0;
        s_axi_araddr  = addr;
        s_axi_arvalid = 1'b1;
        n = 0;
        do begin
            @(negedge aclk);
            n++;
        end while (!s_axi_arready && n < WAIT_LIMIT);
        if (!s_axi_arready) begin
            $display("Timeout at %0t waiting for the read address ready", $time);
            timeouts++;
        end else begin
            @(negedge aclk);   // Valid held over the handshake edge
        end
        s_axi_arvalid = 1'b0;
        n = 0;
        while (!s_axi_rvalid && n < WAIT_LIMIT) begin
            @(negedge aclk);
            n++;
        end
        if (!s_axi_rvalid) begin
            $display("Timeout at %0t waiting for read data", $time);
            timeouts++;
        end else begin
            data = s_axi_rdata;
            if (s_axi_rresp != 2'b00) begin
                $display("Error: %0t s_axi_rresp expected %h actual %h", $time, 2'b00, s_axi_rresp);
                errors++;
            end
            s_axi_rready = 1'b1;
            @(negedge aclk);
            s_axi_rready = 1'b0;
        end
    endtask

    // Reads a register until it shows the wanted value
    task automatic poll_reg(input logic [4:0] addr, input logic [31:0] want);
        logic [31:0] rd;
        int          n;
        n = 0;
        axi_read(addr, rd);
        while (rd != want && n < WAIT_LIMIT) begin
            axi_read(addr, rd);
            n++;
        end
        if (rd != want) begin
            $display("Timeout at %0t polling offset 0x%02h for %08h, last read %08h",
                     $time, addr, want, rd);
            timeouts++;
        end
    endtask

    // Loopback byte; the model drops it once the RX FIFO would be full
    task automatic send_byte(input logic [7:0] b);
        axi_write(5'h0C, {24'd0, b});
        if (rx_model.size() < `UART_FIFO_DEPTH) begin
            rx_model.push_back(b);
        end
    endtask

    task automatic drain_bytes(input int count);
        logic [31:0] rd;
        logic [7:0]  exp;
        int          n;
        for (int i = 0; i < count; i++) begin
            n = 0;
            axi_read(5'h04, rd);
            while (rd[2] && n < WAIT_LIMIT) begin   // Bit 2 is rx_empty
                axi_read(5'h04, rd);
                n++;
            end
            if (rd[2]) begin
                $display("Timeout at %0t waiting for a received byte", $time);
                timeouts++;
            end else if (rx_model.size() == 0) begin
                $display("Golden drain count is larger than the number of bytes sent");
                errors++;
            end else begin
                exp = rx_model.pop_front();
                axi_read(5'h10, rd);
                if (rd != {24'd0, exp}) begin
                    $display("Error: %0t s_axi_rdata (RX data) expected %08h actual %08h",
                             $time, {24'd0, exp}, rd);
                    errors++;
                end
            end
        end
    endtask

    // Hand-built frame with a low stop bit
    task automatic send_bad_frame(input logic [7:0] data);
        logic [9:0] frame;
        int         bit_cycles;
        frame      = {1'b0, data, 1'b0};
        bit_cycles = `UART_OVERSAMPLE * int'(div_model);
        loopback   = 1'b0;
        for (int i = 0; i < 10; i++) begin
            rxd_force = frame[i];
            repeat (bit_cycles) @(negedge aclk);
        end
        rxd_force = 1'b1;
        repeat (2 * bit_cycles) @(negedge aclk);
        loopback = 1'b1;
    endtask

    task automatic run_step(input logic [63:0] op, input logic [31:0] off,
                            input logic [31:0] val);
        logic [31:0] rd;
        if (op == "write") begin
            axi_write(off[4:0], val);
            if (off[4:0] == 5'h08 && wstrb_sel[0]) div_model[7:0] = val[7:0];
            if (off[4:0] == 5'h08 && wstrb_sel[1]) div_model[15:8] = val[15:8];
        end else if (op == "read") begin
            axi_read(off[4:0], rd);
            if (rd != val) begin
                $display("Error: %0t s_axi_rdata (offset 0x%02h) expected %08h actual %08h",
                         $time, off[7:0], val, rd);
                errors++;
            end
        end else if (op == "strobe") begin
            wstrb_sel = val[3:0];
        end else if (op == "send") begin
            send_byte(val[7:0]);
        end else if (op == "burst") begin
            for (int i = 0; i < int'(off); i++) begin
                send_byte(8'(val + i));   // Offset column is the byte count
            end
        end else if (op == "drain") begin
            drain_bytes(int'(val));
        end else if (op == "poll") begin
            poll_reg(off[4:0], val);
        end else if (op == "badframe") begin
            send_bad_frame(val[7:0]);
        end else begin
            $display("Unknown opcode in the golden file");
            errors++;
        end
    endtask

    initial begin
        int          fd;
        string       line;
        logic [63:0] op;
        logic [31:0] off;
        logic [31:0] val;
        errors        = 0;
        timeouts      = 0;
        aresetn       = 1'b0;
        s_axi_awaddr  = '0;
        s_axi_awprot  = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wstrb   = '0;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b0;
        s_axi_araddr  = '0;
        s_axi_arprot  = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b0;
        loopback      = 1'b1;
        rxd_force     = 1'b1;
        wstrb_sel     = 4'hF;
        div_model     = 16'(`UART_DEFAULT_DIV);
        repeat (3) @(negedge aclk);
        aresetn = 1'b1;

        // Idle serial line out of reset
        if (uart_txd !== 1'b1) begin
            $display("Error: %0t uart_txd expected 1 actual %b", $time, uart_txd);
            errors++;
        end

        fd = $fopen("uart_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open uart_golden.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) != 0 && line.len() > 1 && line[0] != "#") begin
                    if ($sscanf(line, "%s %h %h", op, off, val) != 3) begin
                        $display("Malformed line in the golden file");
                        errors++;
                    end else begin
                        run_step(op, off, val);
                    end
                end
            end
            $fclose(fd);
        end

        $display("Errors: %0d  Timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* uart_defines.svh */
`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

// Character width in bits
`define UART_DATA_W 8

// Entries per FIFO, power of two and at least 4
`define UART_FIFO_DEPTH 16

// Byte address width of the register window
`define UART_ADDR_W 5

// aclk frequency in Hz
`define UART_CLK_FREQ 100000000

`define UART_DEFAULT_BAUD 115200

// Ticks per serial bit
`define UART_OVERSAMPLE 16

// Reset divisor, 54 with the values above
`define UART_DEFAULT_DIV (`UART_CLK_FREQ / (`UART_DEFAULT_BAUD * `UART_OVERSAMPLE))

`endif

/* uart_golden.txt */
# opcode  offset  value, both in hex; read and poll expect the value at the offset
# strobe sets wstrb, burst sends offset-many bytes from value up, drain reads value bytes
read     00 00000000
read     04 00000005
read     08 00000036
read     14 00000000
strobe   00 3
write    08 abcd0002
read     08 00000002
strobe   00 f
write    00 0000007f
read     00 00000007
read     10 00000000
send     00 55
send     00 a3
send     00 0f
drain    00 3
read     04 00000005
send     00 c6
poll     04 00000001
write    00 00000003
read     10 00000000
read     04 00000001
write    00 00000007
drain    00 1
badframe 00 5a
poll     04 00000015
read     10 00000000
burst    11 80
poll     04 00000039
drain    00 10
read     10 00000000
read     04 00000035

/* uart_pkg.sv */
package uart_pkg;

    // Word offsets, byte address bits [4:2]
    typedef enum logic [2:0] {
        REG_CTRL    = 3'd0,   // 0x00
        REG_STATUS  = 3'd1,   // 0x04
        REG_BAUD    = 3'd2,   // 0x08
        REG_TX_DATA = 3'd3,   // 0x0C
        REG_RX_DATA = 3'd4    // 0x10
    } reg_addr_t;

    typedef struct packed {
        logic rx_en;
        logic tx_en;
        logic enable;         // Bit 0, master enable
    } uart_ctrl_t;

    typedef struct packed {
        logic overrun_err;    // Bit 5, sticky
        logic frame_err;      // Sticky
        logic rx_full;
        logic rx_empty;
        logic tx_full;
        logic tx_empty;       // Bit 0
    } uart_status_t;

    // One-cycle pulses from the receiver
    typedef struct packed {
        logic frame;
        logic overrun;
    } rx_err_t;

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

endpackage

/* uart_rx.sv */
`timescale 1ns/10ps
`include "uart_defines.svh"

module uart_rx (
    input  logic                    aclk,
    input  logic                    aresetn,
    input  uart_pkg::uart_ctrl_t    ctrl,
    input  logic                    tick,
    input  logic                    rxd,
    input  logic                    fifo_full,
    output logic                    fifo_push,
    output logic [`UART_DATA_W-1:0] fifo_data,
    output uart_pkg::rx_err_t       err
);
    localparam logic [3:0] TICK_LAST = 4'(`UART_OVERSAMPLE - 1);
    localparam logic [3:0] TICK_HALF = 4'(`UART_OVERSAMPLE / 2 - 1);
    localparam logic [2:0] BIT_LAST  = 3'(`UART_DATA_W - 1);

    uart_pkg::rx_state_t     state;
    logic                    rxd_meta;
    logic                    rxd_sync;
    logic                    rxd_prev;
    logic [3:0]              tick_cnt;
    logic [2:0]              bit_cnt;
    logic [`UART_DATA_W-1:0] shift;
    logic                    sample;

    // Start bit is sampled half a bit in, the rest a full bit apart
    assign sample    = tick && (tick_cnt == ((state == uart_pkg::RX_START) ? TICK_HALF : TICK_LAST));
    assign fifo_data = shift;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;   // For falling edge detect
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn || state == uart_pkg::RX_IDLE) begin
            tick_cnt <= '0;
        end else if (tick) begin
            tick_cnt <= sample ? 4'd0 : tick_cnt + 4'd1;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state     <= uart_pkg::RX_IDLE;
            bit_cnt   <= '0;
            fifo_push <= 1'b0;
            err       <= '0;
        end else begin
            fifo_push <= 1'b0;
            err       <= '0;
            if (!(ctrl.enable && ctrl.rx_en)) begin
                state <= uart_pkg::RX_IDLE;
            end else begin
                case (state)
                    uart_pkg::RX_IDLE: begin
                        if (rxd_prev && !rxd_sync) begin
                            state <= uart_pkg::RX_START;
                        end
                    end
                    uart_pkg::RX_START: begin
                        if (sample) begin   // High here means a glitch, not a start
                            bit_cnt <= '0;
                            state   <= rxd_sync ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
                        end
                    end
                    uart_pkg::RX_DATA: begin
                        if (sample) begin
                            shift   <= {rxd_sync, shift[`UART_DATA_W-1:1]};
                            bit_cnt <= bit_cnt + 3'd1;
                            if (bit_cnt == BIT_LAST) begin
                                state <= uart_pkg::RX_STOP;
                            end
                        end
                    end
                    default: begin
                        if (sample) begin
                            state <= uart_pkg::RX_IDLE;
                            if (!rxd_sync) begin
                                err.frame <= 1'b1;
                            end else if (fifo_full) begin
                                err.overrun <= 1'b1;   // Byte is lost
                            end else begin
                                fifo_push <= 1'b1;
                            end
                        end
                    end
                endcase
            end
        end
    end

    // Each frame ends in exactly one outcome
    a_one_outcome : assert property (@(posedge aclk) disable iff (!aresetn)
        !(fifo_push && (err.frame || err.overrun)));

endmodule

/* uart_tx.sv */
`timescale 1ns/10ps
`include "uart_defines.svh"

module uart_tx (
    input  logic                    aclk,
    input  logic                    aresetn,
    input  uart_pkg::uart_ctrl_t    ctrl,
    input  logic                    tick,
    input  logic                    fifo_empty,
    input  logic [`UART_DATA_W-1:0] fifo_data,
    output logic                    fifo_pop,
    output logic                    txd
);
    localparam logic [3:0] TICK_LAST = 4'(`UART_OVERSAMPLE - 1);
    localparam logic [2:0] BIT_LAST  = 3'(`UART_DATA_W - 1);

    uart_pkg::tx_state_t     state;
    logic [3:0]              tick_cnt;
    logic [2:0]              bit_cnt;
    logic [`UART_DATA_W-1:0] shift;
    logic                    tx_on;
    logic                    bit_end;

    assign tx_on    = ctrl.enable && ctrl.tx_en;
    assign fifo_pop = tx_on && (state == uart_pkg::TX_IDLE) && !fifo_empty;
    assign bit_end  = tick && (tick_cnt == TICK_LAST);

    // Held at zero until the start bit has gone out on a tick
    always_ff @(posedge aclk) begin
        if (!aresetn || state == uart_pkg::TX_IDLE || (state == uart_pkg::TX_START && txd)) begin
            tick_cnt <= '0;
        end else if (tick) begin
            tick_cnt <= bit_end ? 4'd0 : tick_cnt + 4'd1;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state   <= uart_pkg::TX_IDLE;
            bit_cnt <= '0;
            txd     <= 1'b1;
        end else if (!tx_on) begin
            state <= uart_pkg::TX_IDLE;
            txd   <= 1'b1;                          // Idle line
        end else begin
            case (state)
                uart_pkg::TX_IDLE: begin
                    if (fifo_pop) begin
                        shift <= fifo_data;         // Head latched as it is popped
                        state <= uart_pkg::TX_START;
                    end
                end
                uart_pkg::TX_START: begin
                    if (tick && txd) begin
                        txd <= 1'b0;
                    end else if (bit_end) begin
                        txd     <= shift[0];        // LSB first
                        shift   <= shift >> 1;
                        bit_cnt <= '0;
                        state   <= uart_pkg::TX_DATA;
                    end
                end
                uart_pkg::TX_DATA: begin
                    if (bit_end) begin
                        if (bit_cnt == BIT_LAST) begin
                            txd   <= 1'b1;          // Stop bit
                            state <= uart_pkg::TX_STOP;
                        end else begin
                            txd     <= shift[0];
                            shift   <= shift >> 1;
                            bit_cnt <= bit_cnt + 3'd1;
                        end
                    end
                end
                default: begin
                    if (bit_end) begin
                        state <= uart_pkg::TX_IDLE;
                    end
                end
            endcase
        end
    end

endmodule
